// ==== filelist.f ====
verilog/mem_test_pkg.sv
verilog/uart_tx_frame.sv
verilog/burst_compare.sv
verilog/mem_test_sequencer.sv
verilog/sdram_burst_test_top.sv
tests/tb_checker.sv
tests/tb_top.sv

// ==== tests/tb_checker.sv ====
`default_nettype none

module tb_checker #(
    parameter int FRAME_WORDS = 16
) (
    input wire                          clk_133MHz_210,
    input wire                          rst_n,
    input wire                          mem_wr_req,
    input wire                          mem_rd_req,
    input wire mem_test_pkg::mem_addr_t mem_addr,
    input wire mem_test_pkg::mem_word_t mem_wr_data_0,
    input wire mem_test_pkg::mem_word_t mem_wr_data_1,
    input wire mem_test_pkg::mem_word_t mem_wr_data_2,
    input wire mem_test_pkg::mem_word_t mem_wr_data_3,
    input wire                          txd,
    input wire                          led,
    input wire                          test_done
);

    import mem_test_pkg::*;

    localparam int ROUNDS       = FRAME_WORDS / BURST_WORDS;
    localparam int FRAME_CYCLES = UART_FRAME_BITS * BAUD_DIVISOR;

    int error_count  = 0;
    int test_errors  = 0;  // Errors of the test in progress.
    int tests_run    = 0;
    int tests_failed = 0;

    // Expected behavior.
    int   fault_round = -1;  // Faulted round or -1.
    int   fault_word  = 0;
    int   wr_count;          // Write bursts seen.
    int   cur_round;
    int   frame_idx;         // Bytes seen in this round.
    logic prev_wr;
    logic prev_rd;
    logic prev_led;
    logic prev_done;

    // UART decoder.
    logic                       dec_active;
    logic                       bit_first;  // Level at the start of the bit.
    logic                       frame_ok;
    logic [UART_FRAME_BITS-1:0] frame_bits;
    int                         dec_cnt;

    // Bytes a round may report before the tester stops.
    function automatic int bytes_due(input int round);
        if (fault_round >= 0 && round == fault_round) return 2 * fault_word;
        return REPORT_BYTES;
    endfunction

    // All four words of round n hold n, high byte first.
    function automatic tx_byte_t pattern_byte(input int round, input int idx);
        mem_word_t word;
        word = mem_word_t'(round);
        return (idx % 2 == 0) ? word[15:8] : word[7:0];
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            error_count++;
            test_errors++;
            $display("Fail at %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic report_problem(input string what);
        error_count++;
        test_errors++;
        $display("Error at %0t: %s", $time, what);
    endtask

    task automatic start_run(input int round, input int word);
        fault_round = round;
        fault_word  = word;
        test_errors = 0;
    endtask

    task automatic finish_test(input string name);
        if (dec_active) report_problem("a UART frame was still on the line at the end");
        check_value("led", led, fault_round >= 0);
        check_value("test_done", test_done, fault_round < 0);
        check_value("write bursts", wr_count, fault_round < 0 ? ROUNDS : fault_round + 1);
        check_value("bytes in last round", frame_idx, bytes_due(cur_round));
        tests_run++;
        if (test_errors == 0) begin
            $display("%s: passed", name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", name, test_errors);
        end
    endtask

    task automatic frame_done();
        if (!frame_ok) report_problem("a UART bit changed level before its full bit time");
        check_value("txd start bit", frame_bits[0], 1'b0);
        check_value("txd stop bits", frame_bits[10:9], 2'b11);
        if (frame_idx >= bytes_due(cur_round))
            report_problem("a UART frame was sent after the expected bytes");
        else
            check_value("txd byte", frame_bits[8:1], pattern_byte(cur_round, frame_idx));
        frame_idx++;
    endtask

////////////////////////////////////////////////////////////////////////////
// Port watch, sampled mid-cycle.
////////////////////////////////////////////////////////////////////////////
    always @(negedge clk_133MHz_210) begin
        if (!rst_n) begin
            check_value("txd", txd, 1'b1);
            check_value("{mem_wr_req,mem_rd_req,led,test_done}",
                        {mem_wr_req, mem_rd_req, led, test_done}, '0);
            wr_count   = 0;
            cur_round  = 0;
            frame_idx  = 0;
            dec_active = 1'b0;
            prev_wr    = 1'b0;
            prev_rd    = 1'b0;
            prev_led   = 1'b0;
            prev_done  = 1'b0;
        end else begin
            if (mem_wr_req && mem_rd_req) report_problem("write and read requests overlap");
            if ((mem_wr_req && !prev_wr || mem_rd_req && !prev_rd) && (led || test_done))
                report_problem("memory request after the tester stopped");
            if (mem_wr_req && !prev_wr) begin  // New round.
                if (wr_count > 0) check_value("bytes per round", frame_idx, REPORT_BYTES);
                cur_round = wr_count;
                wr_count++;
                frame_idx = 0;
            end
            // Address and data held for the whole request.
            if (mem_wr_req || mem_rd_req)
                check_value("mem_addr", mem_addr, BURST_WORDS * cur_round);
            if (mem_wr_req) begin
                check_value("mem_wr_data_0", mem_wr_data_0, cur_round);
                check_value("mem_wr_data_1", mem_wr_data_1, cur_round);
                check_value("mem_wr_data_2", mem_wr_data_2, cur_round);
                check_value("mem_wr_data_3", mem_wr_data_3, cur_round);
            end
            if (led && !prev_led) begin
                if (fault_round < 0) report_problem("led rose without a corrupted read");
                check_value("bytes before led", frame_idx, bytes_due(cur_round));
            end
            if (test_done && !prev_done) begin
                if (fault_round >= 0) report_problem("test_done rose despite a bad word");
                check_value("write bursts at test_done", wr_count, ROUNDS);
            end
            if (prev_led && !led) report_problem("led fell without a reset");

            // Frame decode, start bit found on its first cycle.
            if (!dec_active && txd === 1'b0) begin
                dec_active = 1'b1;
                dec_cnt    = 0;
                frame_ok   = 1'b1;
            end
            if (dec_active) begin
                if (dec_cnt % BAUD_DIVISOR == 0) bit_first = txd;
                else if (txd !== bit_first) frame_ok = 1'b0;
                if (dec_cnt % BAUD_DIVISOR == BAUD_DIVISOR / 2)
                    frame_bits[dec_cnt / BAUD_DIVISOR] = txd;  // Mid-bit.
                dec_cnt++;
                if (dec_cnt == FRAME_CYCLES) begin
                    dec_active = 1'b0;
                    frame_done();
                end
            end
            prev_wr   = mem_wr_req;
            prev_rd   = mem_rd_req;
            prev_led  = led;
            prev_done = test_done;
        end
    end

endmodule

`default_nettype wire

// ==== tests/tb_top.sv ====
`default_nettype none

module tb_top;

    import mem_test_pkg::*;

    localparam int PAUSE_CYCLES = 64;
    localparam int FRAME_WORDS  = 16;     // Four rounds.
    localparam int MAX_LATENCY  = 20;     // Memory answers in 1..20 cycles.
    localparam int FAULT_ROUND  = 3;
    localparam int RESET_CYCLES = 16;
    localparam int RUN_TIMEOUT  = 700000; // A clean frame needs about 410k cycles.
    localparam int QUIET_CYCLES = 2 * UART_FRAME_BITS * BAUD_DIVISOR;

    logic                            clk_133MHz_210 = 1'b0;  // First edge at time 2.
    logic                            rst_n;
    logic                            mem_wr_done;
    logic                            mem_rd_done;
    mem_word_t                       mem_rd_data_0;
    mem_word_t                       mem_rd_data_1;
    mem_word_t                       mem_rd_data_2;
    mem_word_t                       mem_rd_data_3;
    wire                             mem_wr_req;
    wire                             mem_rd_req;
    wire mem_addr_t                  mem_addr;
    wire mem_word_t                  mem_wr_data_0;
    wire mem_word_t                  mem_wr_data_1;
    wire mem_word_t                  mem_wr_data_2;
    wire mem_word_t                  mem_wr_data_3;
    wire                             txd;
    wire                             led;
    wire                             test_done;

    integer                          seed;
    logic                            fault_on;    // Corrupt the read of FAULT_ROUND.
    int                              fault_word;
    mem_word_t                       fault_mask;  // One flipped bit.
    logic                            mem_busy;
    int                              mem_wait;
    mem_word_t                       mem_store [mem_addr_t];
    mem_word_t [BURST_WORDS-1:0]     burst;

    sdram_burst_test_top #(
        .PAUSE_CYCLES (PAUSE_CYCLES),
        .FRAME_WORDS  (FRAME_WORDS)
    ) uut (.*);

    tb_checker #(.FRAME_WORDS(FRAME_WORDS)) chk (.*);

    initial begin
        forever #2 clk_133MHz_210 = ~clk_133MHz_210;
    end

////////////////////////////////////////////////////////////////////////////
// Memory model.
////////////////////////////////////////////////////////////////////////////
    // Unwritten words read back as a mix of the whole address.
    function automatic mem_word_t fill_word(input mem_addr_t a);
        return a[15:0] ^ {8'h00, a[23:16]} ^ 16'hA5C3;
    endfunction

    task automatic write_burst();
        mem_store[mem_addr]                  = mem_wr_data_0;
        mem_store[mem_addr_t'(mem_addr + 1)] = mem_wr_data_1;
        mem_store[mem_addr_t'(mem_addr + 2)] = mem_wr_data_2;
        mem_store[mem_addr_t'(mem_addr + 3)] = mem_wr_data_3;
    endtask

    task automatic read_burst();
        mem_addr_t a;
        for (int i = 0; i < BURST_WORDS; i++) begin
            a        = mem_addr_t'(mem_addr + i);
            burst[i] = mem_store.exists(a) ? mem_store[a] : fill_word(a);
        end
        if (fault_on && mem_addr == mem_addr_t'(FAULT_ROUND * BURST_WORDS)) begin
            burst[fault_word] = burst[fault_word] ^ fault_mask;
        end
    endtask

    // One access at a time, done pulse after a random wait.
    always @(posedge clk_133MHz_210) begin
        #1;
        mem_wr_done = 1'b0;
        mem_rd_done = 1'b0;
        burst       = 'x;  // Read data valid with the done pulse only.
        if (!rst_n) begin
            mem_busy = 1'b0;
        end else if (mem_busy || mem_wr_req || mem_rd_req) begin
            if (!mem_busy) begin
                mem_busy = 1'b1;
                mem_wait = 1 + $unsigned($random(seed)) % MAX_LATENCY;
            end
            mem_wait--;
            if (mem_wait == 0) begin
                mem_busy = 1'b0;
                if (mem_wr_req) begin
                    write_burst();
                    mem_wr_done = 1'b1;
                end else begin
                    read_burst();
                    mem_rd_done = 1'b1;
                end
            end
        end
        {mem_rd_data_3, mem_rd_data_2, mem_rd_data_1, mem_rd_data_0} = burst;
    end

////////////////////////////////////////////////////////////////////////////
// Run control.
////////////////////////////////////////////////////////////////////////////
    task automatic release_reset();
        repeat (RESET_CYCLES) @(posedge clk_133MHz_210);
        #1;
        rst_n = 1'b1;
    endtask

    task automatic wait_high(input logic watch_led, input string what);
        int cycles;
        cycles = 0;
        while ((watch_led ? led : test_done) !== 1'b1 && cycles < RUN_TIMEOUT) begin
            @(posedge clk_133MHz_210);
            #1;
            cycles++;
        end
        if ((watch_led ? led : test_done) !== 1'b1) begin
            chk.report_problem($sformatf("timed out after %0d cycles waiting for %s",
                                         cycles, what));
        end
        repeat (QUIET_CYCLES) @(posedge clk_133MHz_210);  // Nothing may follow.
    endtask

    initial begin
        seed          = 74586;
        rst_n         = 1'b0;
        mem_wr_done   = 1'b0;
        mem_rd_done   = 1'b0;
        mem_rd_data_0 = '0;
        mem_rd_data_1 = '0;
        mem_rd_data_2 = '0;
        mem_rd_data_3 = '0;
        fault_on      = 1'b0;
        fault_word    = 0;
        fault_mask    = '0;
        mem_busy      = 1'b0;
        mem_wait      = 0;

        // Clean memory, whole frame.
        chk.start_run(-1, 0);
        release_reset();
        wait_high(1'b0, "test_done");
        chk.finish_test("fault-free run");

        // Same frame again, one word of the last burst corrupted.
        fault_word = $unsigned($random(seed)) % BURST_WORDS;
        fault_mask = mem_word_t'(1) << ($unsigned($random(seed)) % MEM_WORD_W);
        fault_on   = 1'b1;
        @(posedge clk_133MHz_210);
        #1;
        rst_n = 1'b0;
        chk.start_run(FAULT_ROUND, fault_word);
        release_reset();
        wait_high(1'b1, "led");
        chk.finish_test($sformatf("fault run, word %0d corrupted", fault_word));

        $display("Tests run: %0d, failed: %0d, errors: %0d",
                 chk.tests_run, chk.tests_failed, chk.error_count);
        if (chk.error_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/burst_compare.sv ====
`default_nettype none

module burst_compare (
    input  wire                                  clk_133MHz_210,
    input  wire                                  rst_n,
    input  wire                                  mem_rd_done,    // Data valid this cycle only.
    input  wire mem_test_pkg::mem_word_t         mem_rd_data_0,
    input  wire mem_test_pkg::mem_word_t         mem_rd_data_1,
    input  wire mem_test_pkg::mem_word_t         mem_rd_data_2,
    input  wire mem_test_pkg::mem_word_t         mem_rd_data_3,
    input  wire mem_test_pkg::mem_word_t         expected_0,     // Pattern last written.
    input  wire mem_test_pkg::mem_word_t         expected_1,
    input  wire mem_test_pkg::mem_word_t         expected_2,
    input  wire mem_test_pkg::mem_word_t         expected_3,
    input  wire [mem_test_pkg::BYTE_INDEX_W-1:0] byte_index,     // Report step 0..7.
    output mem_test_pkg::tx_byte_t               report_byte,
    output logic                                 mismatch
);

    import mem_test_pkg::*;

    localparam int WORD_SEL_W = $clog2(BURST_WORDS);

    mem_word_t              rd_word [BURST_WORDS];  // Captured burst.
    logic [BURST_WORDS-1:0] word_bad;               // One flag per word.
    logic [WORD_SEL_W-1:0]  word_sel;
    mem_word_t              sel_word;

////////////////////////////////////////////////////////////////////////////
// Capture.
////////////////////////////////////////////////////////////////////////////
    // Burst data held for the whole report phase.
    always_ff @(posedge clk_133MHz_210) begin
        if (mem_rd_done) begin
            rd_word[0] <= mem_rd_data_0;
            rd_word[1] <= mem_rd_data_1;
            rd_word[2] <= mem_rd_data_2;
            rd_word[3] <= mem_rd_data_3;
        end
    end

    // Expected words hold still during the read, so compare on the way in.
    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            word_bad <= '0;
        end else if (mem_rd_done) begin
            word_bad[0] <= (mem_rd_data_0 != expected_0);
            word_bad[1] <= (mem_rd_data_1 != expected_1);
            word_bad[2] <= (mem_rd_data_2 != expected_2);
            word_bad[3] <= (mem_rd_data_3 != expected_3);
        end
    end

////////////////////////////////////////////////////////////////////////////
// Byte select.
////////////////////////////////////////////////////////////////////////////
    assign word_sel = byte_index[BYTE_INDEX_W-1:1];  // Two bytes per word.
    assign sel_word = rd_word[word_sel];
    assign mismatch = word_bad[word_sel];

    // Even step is the high byte.
    assign report_byte = byte_index[0] ? sel_word[TX_BYTE_W-1:0]
                                       : sel_word[MEM_WORD_W-1 -: TX_BYTE_W];

endmodule

`default_nettype wire

// ==== verilog/mem_test_pkg.sv ====
`default_nettype none

package mem_test_pkg;

////////////////////////////////////////////////////////////////////////////
// Memory port widths.
////////////////////////////////////////////////////////////////////////////
    localparam int MEM_ADDR_W = 24;  // Bank(2) + row(13) + column(9).
    localparam int MEM_WORD_W = 16;  // One SDRAM data word.
    localparam int TX_BYTE_W  = 8;

    typedef logic [MEM_ADDR_W-1:0] mem_addr_t;
    typedef logic [MEM_WORD_W-1:0] mem_word_t;
    typedef logic [TX_BYTE_W-1:0]  tx_byte_t;

    // Burst and report shape.
    localparam int BURST_WORDS  = 4;
    localparam int REPORT_BYTES = 2 * BURST_WORDS;  // High, then low byte per word.
    localparam int BYTE_INDEX_W = $clog2(REPORT_BYTES);

////////////////////////////////////////////////////////////////////////////
// UART framing.
////////////////////////////////////////////////////////////////////////////
    // 133.33 MHz / 115200 baud.
    localparam int BAUD_DIVISOR    = 1157;
    localparam int BAUD_CNT_W      = $clog2(BAUD_DIVISOR);
    localparam int UART_FRAME_BITS = 11;  // Start, 8 data LSB first, 2 stop.
    localparam int FRAME_BIT_CNT_W = $clog2(UART_FRAME_BITS);

    // Frame buffer and round pacing.
    localparam int LCD_FRAME_WORDS    = 480 * 800;  // One 800x480 screen.
    localparam int ROUND_PAUSE_CYCLES = 2222222;    // About 16.7 ms.

////////////////////////////////////////////////////////////////////////////
// State machines.
////////////////////////////////////////////////////////////////////////////
    typedef enum logic [2:0] {
        ST_WRITE,    // Burst write, request held until done.
        ST_READ,     // Burst read back.
        ST_REPORT,   // Check word, hand one byte to UART.
        ST_WAIT_TX,  // Frame on the line.
        ST_PAUSE,
        ST_HALT,     // Compare error, sticky.
        ST_DONE
    } seq_state_t;

    typedef enum logic {
        TX_IDLE,
        TX_SHIFT
    } tx_state_t;

endpackage

`default_nettype wire

// ==== verilog/mem_test_sequencer.sv ====
`default_nettype none

module mem_test_sequencer #(
    parameter int PAUSE_CYCLES = mem_test_pkg::ROUND_PAUSE_CYCLES,  // Idle time per round.
    parameter int FRAME_WORDS  = mem_test_pkg::LCD_FRAME_WORDS      // Words under test.
) (
    input  wire                                   clk_133MHz_210,
    input  wire                                   rst_n,
    // Memory port.
    input  wire                                   mem_wr_done,  // One-cycle pulse.
    input  wire                                   mem_rd_done,  // One-cycle pulse.
    output logic                                  mem_wr_req,   // Level until done.
    output logic                                  mem_rd_req,
    output mem_test_pkg::mem_addr_t               mem_addr,
    output mem_test_pkg::mem_word_t               mem_wr_data_0,
    output mem_test_pkg::mem_word_t               mem_wr_data_1,
    output mem_test_pkg::mem_word_t               mem_wr_data_2,
    output mem_test_pkg::mem_word_t               mem_wr_data_3,
    // Comparator.
    input  wire                                   mismatch,
    input  wire mem_test_pkg::tx_byte_t           report_byte,
    output mem_test_pkg::mem_word_t               expected_0,
    output mem_test_pkg::mem_word_t               expected_1,
    output mem_test_pkg::mem_word_t               expected_2,
    output mem_test_pkg::mem_word_t               expected_3,
    output logic [mem_test_pkg::BYTE_INDEX_W-1:0] byte_index,
    // UART.
    input  wire                                   tx_busy,
    output logic                                  tx_send,      // One-cycle strobe.
    output mem_test_pkg::tx_byte_t                tx_byte,
    // Status.
    output logic                                  led,          // Compare error.
    output logic                                  test_done
);

    import mem_test_pkg::*;

    localparam int        PAUSE_W    = $clog2(PAUSE_CYCLES + 1);
    localparam mem_addr_t LAST_BLOCK = mem_addr_t'(FRAME_WORDS - BURST_WORDS);

    seq_state_t         state;
    logic [PAUSE_W-1:0] pause_cnt;

    // Read-back is checked against what went out.
    assign expected_0 = mem_wr_data_0;
    assign expected_1 = mem_wr_data_1;
    assign expected_2 = mem_wr_data_2;
    assign expected_3 = mem_wr_data_3;

////////////////////////////////////////////////////////////////////////////
// Round FSM.
////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            state         <= ST_WRITE;
            mem_wr_req    <= 1'b0;
            mem_rd_req    <= 1'b0;
            mem_addr      <= '0;
            mem_wr_data_0 <= '0;
            mem_wr_data_1 <= '0;
            mem_wr_data_2 <= '0;
            mem_wr_data_3 <= '0;
            byte_index    <= '0;
            tx_send       <= 1'b0;
            tx_byte       <= '0;
            pause_cnt     <= '0;
            led           <= 1'b0;
            test_done     <= 1'b0;
        end else begin
            tx_send <= 1'b0;  // Strobe by default.
            case (state)
                ST_WRITE: begin
                    if (mem_wr_done) begin
                        mem_wr_req <= 1'b0;
                        state      <= ST_READ;
                    end else begin
                        mem_wr_req <= 1'b1;
                    end
                end
                ST_READ: begin
                    if (mem_rd_done) begin
                        mem_rd_req <= 1'b0;
                        byte_index <= '0;
                        state      <= ST_REPORT;  // Comparator has the burst next cycle.
                    end else begin
                        mem_rd_req <= 1'b1;
                    end
                end
                ST_REPORT: begin
                    // A word is judged once, at its high byte.
                    if (!byte_index[0] && mismatch) begin
                        led   <= 1'b1;
                        state <= ST_HALT;
                    end else begin
                        tx_send <= 1'b1;
                        tx_byte <= report_byte;
                        state   <= ST_WAIT_TX;
                    end
                end
                ST_WAIT_TX: begin
                    // Busy shows up one edge after the strobe.
                    if (!tx_send && !tx_busy) begin
                        if (byte_index == BYTE_INDEX_W'(REPORT_BYTES - 1)) begin
                            pause_cnt <= '0;
                            state     <= ST_PAUSE;
                        end else begin
                            byte_index <= byte_index + 1'b1;
                            state      <= ST_REPORT;
                        end
                    end
                end
                ST_PAUSE: begin
                    if (pause_cnt == PAUSE_W'(PAUSE_CYCLES - 1)) begin
                        if (mem_addr == LAST_BLOCK) begin
                            test_done <= 1'b1;  // Whole frame covered.
                            state     <= ST_DONE;
                        end else begin
                            mem_addr      <= mem_addr + mem_addr_t'(BURST_WORDS);
                            mem_wr_data_0 <= mem_wr_data_0 + 1'b1;
                            mem_wr_data_1 <= mem_wr_data_1 + 1'b1;
                            mem_wr_data_2 <= mem_wr_data_2 + 1'b1;
                            mem_wr_data_3 <= mem_wr_data_3 + 1'b1;
                            state         <= ST_WRITE;
                        end
                    end else begin
                        pause_cnt <= pause_cnt + 1'b1;
                    end
                end
                ST_HALT: state <= ST_HALT;  // Parked until reset.
                ST_DONE: state <= ST_DONE;
                default: begin
                    led   <= 1'b1;  // Lost state counts as an error.
                    state <= ST_HALT;
                end
            endcase
        end
    end

////////////////////////////////////////////////////////////////////////////
// Checks.
////////////////////////////////////////////////////////////////////////////
    // Only one access on the memory port at a time.
    req_exclusive: assert property (
        @(posedge clk_133MHz_210) disable iff (!rst_n)
        !(mem_wr_req && mem_rd_req)
    );

    // A new byte only reaches an idle UART.
    send_when_idle: assert property (
        @(posedge clk_133MHz_210) disable iff (!rst_n)
        tx_send |-> !tx_busy
    );

endmodule

`default_nettype wire

// ==== verilog/sdram_burst_test_top.sv ====
`default_nettype none

module sdram_burst_test_top #(
    parameter int PAUSE_CYCLES = mem_test_pkg::ROUND_PAUSE_CYCLES,
    parameter int FRAME_WORDS  = mem_test_pkg::LCD_FRAME_WORDS
) (
    input  wire                          clk_133MHz_210,
    input  wire                          rst_n,
    // Burst memory port.
    input  wire                          mem_wr_done,
    input  wire                          mem_rd_done,
    input  wire mem_test_pkg::mem_word_t mem_rd_data_0,
    input  wire mem_test_pkg::mem_word_t mem_rd_data_1,
    input  wire mem_test_pkg::mem_word_t mem_rd_data_2,
    input  wire mem_test_pkg::mem_word_t mem_rd_data_3,
    output wire                          mem_wr_req,
    output wire                          mem_rd_req,
    output wire mem_test_pkg::mem_addr_t mem_addr,
    output wire mem_test_pkg::mem_word_t mem_wr_data_0,
    output wire mem_test_pkg::mem_word_t mem_wr_data_1,
    output wire mem_test_pkg::mem_word_t mem_wr_data_2,
    output wire mem_test_pkg::mem_word_t mem_wr_data_3,
    // Pins.
    output wire                          txd,
    output wire                          led,
    output wire                          test_done
);

    import mem_test_pkg::*;

    // Sequencer and comparator.
    mem_word_t               expected_0;
    mem_word_t               expected_1;
    mem_word_t               expected_2;
    mem_word_t               expected_3;
    logic [BYTE_INDEX_W-1:0] byte_index;
    logic                    mismatch;
    tx_byte_t                report_byte;
    // Sequencer and UART.
    logic                    tx_send;
    tx_byte_t                tx_byte;
    logic                    tx_busy;

////////////////////////////////////////////////////////////////////////////
// Round control.
////////////////////////////////////////////////////////////////////////////
    mem_test_sequencer #(
        .PAUSE_CYCLES (PAUSE_CYCLES),
        .FRAME_WORDS  (FRAME_WORDS)
    ) u_seq (
        .clk_133MHz_210, .rst_n,
        .mem_wr_done, .mem_rd_done, .mem_wr_req, .mem_rd_req, .mem_addr,
        .mem_wr_data_0, .mem_wr_data_1, .mem_wr_data_2, .mem_wr_data_3,
        .mismatch, .report_byte,
        .expected_0, .expected_1, .expected_2, .expected_3, .byte_index,
        .tx_busy, .tx_send, .tx_byte,
        .led, .test_done
    );

    // Read-back check.
    burst_compare u_cmp (
        .clk_133MHz_210, .rst_n, .mem_rd_done,
        .mem_rd_data_0, .mem_rd_data_1, .mem_rd_data_2, .mem_rd_data_3,
        .expected_0, .expected_1, .expected_2, .expected_3,
        .byte_index, .report_byte, .mismatch
    );

    // Report line, 115200 8N2.
    uart_tx_frame u_uart (
        .clk_133MHz_210, .rst_n, .tx_send, .tx_byte, .tx_busy, .txd
    );

endmodule

`default_nettype wire

// ==== verilog/uart_tx_frame.sv ====
`default_nettype none

module uart_tx_frame (
    input  wire                         clk_133MHz_210,
    input  wire                         rst_n,
    input  wire                         tx_send,   // One-cycle strobe.
    input  wire mem_test_pkg::tx_byte_t tx_byte,
    output logic                        tx_busy,
    output logic                        txd
);

    import mem_test_pkg::*;

    logic [UART_FRAME_BITS-1:0] shift_reg;  // Frame bits, next one at [1].
    logic [BAUD_CNT_W-1:0]      bit_timer;  // Cycles within current bit.
    logic [FRAME_BIT_CNT_W-1:0] bit_cnt;    // Bit on the line.
    tx_state_t                  state;

    assign tx_busy = (state == TX_SHIFT);

////////////////////////////////////////////////////////////////////////////
// Bit timing and line driver.
////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            state     <= TX_IDLE;
            txd       <= 1'b1;  // Line idles high.
            bit_timer <= '0;
            bit_cnt   <= '0;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (tx_send) begin
                        txd       <= 1'b0;  // Start bit from the same edge.
                        bit_timer <= '0;
                        bit_cnt   <= '0;
                        state     <= TX_SHIFT;
                    end
                end
                TX_SHIFT: begin
                    if (bit_timer == BAUD_CNT_W'(BAUD_DIVISOR - 1)) begin
                        bit_timer <= '0;
                        txd       <= shift_reg[1];  // Filled ones once the frame is out.
                        // Last stop bit ends the frame.
                        if (bit_cnt == FRAME_BIT_CNT_W'(UART_FRAME_BITS - 1)) begin
                            state <= TX_IDLE;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end else begin
                        bit_timer <= bit_timer + 1'b1;
                    end
                end
            endcase
        end
    end

    // Frame shifter, ones fill in behind.
    always_ff @(posedge clk_133MHz_210) begin
        if (state == TX_IDLE && tx_send) begin
            shift_reg <= {2'b11, tx_byte, 1'b0};
        end else if (state == TX_SHIFT && bit_timer == BAUD_CNT_W'(BAUD_DIVISOR - 1)) begin
            shift_reg <= {1'b1, shift_reg[UART_FRAME_BITS-1:1]};
        end
    end

////////////////////////////////////////////////////////////////////////////
// Checks.
////////////////////////////////////////////////////////////////////////////
    // Idle line stays at mark between frames.
    txd_idle_high: assert property (
        @(posedge clk_133MHz_210) disable iff (!rst_n)
        (state == TX_IDLE) |-> txd
    );

endmodule

`default_nettype wire
